/* Bender.yml */
package:
  name: store_path

sources:
  - include_dirs:
      - .
    files:
      - wb_pkg.sv
      - store_buffer.sv
      - data_array.sv
      - load_merge.sv
      - store_path_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - store_path_assert.sv
      - tb_store_path.sv

/* all.f */
+incdir+.
wb_pkg.sv
store_buffer.sv
data_array.sv
load_merge.sv
store_path_top.sv
store_path_assert.sv
tb_store_path.sv

/* data_array.sv */
/*
  Single-port data array of the bank with per-byte write enables.
  Loads own the port when they fire; buffered stores are written in the idle cycles.
*/

`timescale 1ns/1ps

`include "wb_consts.svh"

module data_array (
  input  logic                 clk_i,
  input  logic                 reset_i,

  input  logic                 rd_v_i,
  input  wb_pkg::addr_t        rd_addr_i,
  output wb_pkg::data_t        rd_data_o,

  input  logic                 drain_valid_i,
  input  wb_pkg::store_entry_t drain_entry_i,
  output logic                 drain_yumi_o
);

  wb_pkg::data_t      mem_q [`WB_WORDS];
  wb_pkg::word_addr_t rd_word;
  wb_pkg::word_addr_t wr_word;
  logic               wr_en;

  assign rd_word = rd_addr_i[`WB_ADDR_W-1:`WB_OFFSET_W];
  assign wr_word = drain_entry_i.addr[`WB_ADDR_W-1:`WB_OFFSET_W];

  // ##############################
  // port arbitration

  // a read takes the port, and the drain waits for the next free cycle.
  assign wr_en        = drain_valid_i & ~rd_v_i;
  assign drain_yumi_o = wr_en;

  // ##############################
  // storage

  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      for (int b = 0; b < `WB_MASK_W; b++) begin
        if (drain_entry_i.mask[b]) begin
          mem_q[wr_word][8*b +: 8] <= drain_entry_i.data[8*b +: 8];
        end
      end
    end
  end

  // read data stays put between reads.
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rd_data_o <= '0;
    end else if (rd_v_i) begin
      rd_data_o <= mem_q[rd_word];
    end
  end

endmodule

/* load_merge.sv */
/*
  Result stage for loads. It owns the load handshake and one result slot,
  and overlays the buffered store bytes on the word read from the array.
*/

`timescale 1ns/1ps

`include "wb_consts.svh"

module load_merge (
  input  logic            clk_i,
  input  logic            reset_i,

  input  logic            load_valid_i,
  output logic            load_ready_o,
  output logic            load_fire_o,

  input  wb_pkg::bypass_t bypass_i,
  input  wb_pkg::data_t   rd_data_i,

  output logic            result_valid_o,
  input  logic            result_ready_i,
  output wb_pkg::data_t   result_data_o
);

  // ##############################
  // handshake

  // a new load may enter while the current result leaves.
  assign load_ready_o = ~result_valid_o | result_ready_i;
  assign load_fire_o  = load_valid_i & load_ready_o;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      result_valid_o <= 1'b0;
    end else if (load_fire_o) begin
      result_valid_o <= 1'b1;
    end else if (result_ready_i) begin
      result_valid_o <= 1'b0;
    end
  end

  // ##############################
  // byte merge

  // both inputs are registers that only move on a load fire.
  always_comb begin
    for (int b = 0; b < `WB_MASK_W; b++) begin
      if (bypass_i.mask[b]) begin
        result_data_o[8*b +: 8] = bypass_i.data[8*b +: 8];
      end else begin
        result_data_o[8*b +: 8] = rd_data_i[8*b +: 8];
      end
    end
  end

endmodule

/* store_buffer.sv */
/*
  Two-entry store buffer. Accepted stores wait here until the array port is free,
  while loads look the entries up so they see bytes not yet written to the array.
*/

`timescale 1ns/1ps

`include "wb_consts.svh"

module store_buffer (
  input  logic                 clk_i,
  input  logic                 reset_i,

  input  logic                 store_valid_i,
  input  wb_pkg::store_entry_t store_entry_i,
  output logic                 store_ready_o,

  output logic                 drain_valid_o,
  output wb_pkg::store_entry_t drain_entry_o,
  input  logic                 drain_yumi_i,

  input  logic                 lookup_v_i,
  input  wb_pkg::addr_t        lookup_addr_i,
  output wb_pkg::bypass_t      bypass_o
);

  // ##############################
  // queue

  wb_pkg::store_entry_t head_q;
  wb_pkg::store_entry_t tail_q;
  logic                 head_v_q;
  logic                 tail_v_q;
  logic                 store_fire;

  // the tail only fills behind a valid head, so a valid tail means the buffer is full.
  assign store_ready_o = ~tail_v_q;
  assign store_fire    = store_valid_i & store_ready_o;

  assign drain_valid_o = head_v_q;
  assign drain_entry_o = head_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      head_v_q <= 1'b0;
      tail_v_q <= 1'b0;
    end else if (drain_yumi_i) begin
      // a full buffer takes no store, so after a drain at most one entry is left.
      head_v_q <= tail_v_q | store_fire;
      tail_v_q <= 1'b0;
    end else if (store_fire) begin
      head_v_q <= 1'b1;
      tail_v_q <= head_v_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (drain_yumi_i) begin
      head_q <= tail_v_q ? tail_q : store_entry_i;
    end else if (store_fire && !head_v_q) begin
      head_q <= store_entry_i;
    end

    if (store_fire && head_v_q && !drain_yumi_i) begin
      tail_q <= store_entry_i;
    end
  end

  // ##############################
  // load bypass

  wb_pkg::word_addr_t lookup_word;
  logic               hit_head;
  logic               hit_tail;
  logic               hit_in;
  wb_pkg::mask_t      sel_head;
  wb_pkg::mask_t      sel_tail;
  wb_pkg::mask_t      sel_in;
  wb_pkg::bypass_t    bypass_n;

  function automatic wb_pkg::word_addr_t word_of(wb_pkg::addr_t addr);
    return addr[`WB_ADDR_W-1:`WB_OFFSET_W];
  endfunction

  assign lookup_word = word_of(lookup_addr_i);

  // a store transferring this cycle counts as well.
  assign hit_head = head_v_q && (word_of(head_q.addr) == lookup_word);
  assign hit_tail = tail_v_q && (word_of(tail_q.addr) == lookup_word);
  assign hit_in   = store_fire && (word_of(store_entry_i.addr) == lookup_word);

  assign sel_head = hit_head ? head_q.mask : '0;
  assign sel_tail = hit_tail ? tail_q.mask : '0;
  assign sel_in   = hit_in ? store_entry_i.mask : '0;

  // newest store wins each byte: incoming, then tail, then head.
  always_comb begin
    bypass_n.mask = sel_head | sel_tail | sel_in;
    for (int b = 0; b < `WB_MASK_W; b++) begin
      if (sel_in[b]) begin
        bypass_n.data[8*b +: 8] = store_entry_i.data[8*b +: 8];
      end else if (sel_tail[b]) begin
        bypass_n.data[8*b +: 8] = tail_q.data[8*b +: 8];
      end else begin
        bypass_n.data[8*b +: 8] = head_q.data[8*b +: 8];
      end
    end
  end

  // held until the next load, which keeps a stalled result stable.
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      bypass_o <= '0;
    end else if (lookup_v_i) begin
      bypass_o <= bypass_n;
    end
  end

endmodule

/* store_path_assert.sv */
/*
  Concurrent checks on the store path handshakes.
  Bound into store_path_top, where it also watches the drain acknowledge.
*/

`timescale 1ns/1ps

module store_path_assert (
  input logic          clk_i,
  input logic          reset_i,
  input logic          store_valid_i,
  input logic          store_ready_i,
  input logic          load_ready_i,
  input logic          result_valid_i,
  input logic          result_ready_i,
  input wb_pkg::data_t result_data_i,
  input logic          drain_valid_i,
  input logic          drain_yumi_i
);

  // ##############################
  // result channel

  // a stalled result keeps both its valid and its data.
  result_stable: assert property (
    @(posedge clk_i) disable iff (reset_i)
    result_valid_i && !result_ready_i |=> result_valid_i && $stable(result_data_i)
  ) else $error("result changed while stalled");

  reset_values: assert property (
    @(posedge clk_i) reset_i |=> !result_valid_i && store_ready_i && load_ready_i
  ) else $error("handshake outputs not at their reset values");

  // ##############################
  // store buffer fill

  // the buffer fills only when a store enters behind a head that is not draining.
  full_after_two: assert property (
    @(posedge clk_i) disable iff (reset_i)
    $fell(store_ready_i) |->
      $past(store_valid_i && store_ready_i && drain_valid_i && !drain_yumi_i)
  ) else $error("store ready fell without two stores held");

  full_until_drain: assert property (
    @(posedge clk_i) disable iff (reset_i)
    !store_ready_i && !drain_yumi_i |=> !store_ready_i
  ) else $error("store ready rose without a drain");

endmodule

bind store_path_top store_path_assert u_store_path_assert (
  .clk_i          (clk_i),
  .reset_i        (reset_i),
  .store_valid_i  (store_valid_i),
  .store_ready_i  (store_ready_o),
  .load_ready_i   (load_ready_o),
  .result_valid_i (result_valid_o),
  .result_ready_i (result_ready_i),
  .result_data_i  (result_data_o),
  .drain_valid_i  (drain_valid),
  .drain_yumi_i   (drain_yumi)
);

/* store_path_top.sv */
/*
  Data path of one cache bank with a store buffer in front of the array.
  Stores, loads and load results each use a valid/ready channel.
*/

`timescale 1ns/1ps

module store_path_top (
  input  logic                 clk_i,
  input  logic                 reset_i,

  // store channel.
  input  logic                 store_valid_i,
  output logic                 store_ready_o,
  input  wb_pkg::store_entry_t store_i,

  // load channel.
  input  logic                 load_valid_i,
  output logic                 load_ready_o,
  input  wb_pkg::addr_t        load_addr_i,

  // result channel.
  output logic                 result_valid_o,
  input  logic                 result_ready_i,
  output wb_pkg::data_t        result_data_o
);

  logic                 drain_valid;
  wb_pkg::store_entry_t drain_entry;
  logic                 drain_yumi;
  logic                 load_fire;
  wb_pkg::bypass_t      bypass;
  wb_pkg::data_t        rd_data;

  // ##############################
  // buffer and array side by side

  store_buffer u_store_buffer (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .store_valid_i (store_valid_i),
    .store_entry_i (store_i),
    .store_ready_o (store_ready_o),
    .drain_valid_o (drain_valid),
    .drain_entry_o (drain_entry),
    .drain_yumi_i  (drain_yumi),
    .lookup_v_i    (load_fire),
    .lookup_addr_i (load_addr_i),
    .bypass_o      (bypass)
  );

  data_array u_data_array (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .rd_v_i        (load_fire),
    .rd_addr_i     (load_addr_i),
    .rd_data_o     (rd_data),
    .drain_valid_i (drain_valid),
    .drain_entry_i (drain_entry),
    .drain_yumi_o  (drain_yumi)
  );

  // ##############################
  // load result

  load_merge u_load_merge (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .load_valid_i   (load_valid_i),
    .load_ready_o   (load_ready_o),
    .load_fire_o    (load_fire),
    .bypass_i       (bypass),
    .rd_data_i      (rd_data),
    .result_valid_o (result_valid_o),
    .result_ready_i (result_ready_i),
    .result_data_o  (result_data_o)
  );

endmodule

/* tb_store_path.sv */
/*
  Testbench for store_path_top. A table of stores and loads runs first, then
  random result back-pressure and a store stall under continuous loads.
*/

`timescale 1ns/1ps

`include "wb_consts.svh"

module tb_store_path;

  localparam logic [1:0] OP_ST = 2'd0;
  localparam logic [1:0] OP_LD = 2'd1;
  localparam logic [1:0] OP_SL = 2'd2;
  localparam int TIMEOUT = 200;
  localparam int REGION_BASE = 'h040;

  typedef struct packed {
    logic [2:0]    test;
    logic [1:0]    op;
    wb_pkg::addr_t addr;
    wb_pkg::data_t data;
    wb_pkg::mask_t mask;
    wb_pkg::data_t exp;
  } row_t;

  logic                 clk_i = 1'b0;
  logic                 reset_i;
  logic                 store_valid_i;
  logic                 store_ready_o;
  wb_pkg::store_entry_t store_i;
  logic                 load_valid_i;
  logic                 load_ready_o;
  wb_pkg::addr_t        load_addr_i;
  logic                 result_valid_o;
  logic                 result_ready_i;
  wb_pkg::data_t        result_data_o;

  row_t          rows [$];
  string         test_names [6] = '{"full_words", "partial_merge", "same_cycle",
                                    "overlap", "random_ready", "store_stall"};
  logic [7:0]    ref_mem [1 << `WB_ADDR_W];
  wb_pkg::data_t exp_q [$];
  wb_pkg::data_t cur_exp;
  wb_pkg::data_t held_data;
  logic          held_v = 1'b0;
  logic          exp_from_ref = 1'b0;
  logic          st_fired;
  logic          ld_fired;
  logic [31:0]   lfsr_state = 32'hecd7;
  string         cur_name = "reset";
  int            tests = 0;
  int            checks = 0;
  int            errors = 0;
  int            t_checks = 0;
  int            t_errors = 0;

  store_path_top u_store_path_top (.*);

  always #20 clk_i = ~clk_i;

  // ##############################
  // random bits and reference

  // taps 32, 22, 2, 1.
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  function automatic wb_pkg::addr_t region_addr();
    return wb_pkg::addr_t'(REGION_BASE + rand_bits(5));
  endfunction

  function automatic wb_pkg::store_entry_t random_store();
    wb_pkg::store_entry_t s;
    s.addr = region_addr();
    s.data = rand_bits(32);
    s.mask = wb_pkg::mask_t'(rand_bits(`WB_MASK_W));
    return s;
  endfunction

  function automatic int word_base(input wb_pkg::addr_t a);
    return int'(a[`WB_ADDR_W-1:`WB_OFFSET_W]) * `WB_MASK_W;
  endfunction

  task automatic write_ref(input wb_pkg::store_entry_t s);
    for (int b = 0; b < `WB_MASK_W; b++) begin
      if (s.mask[b]) begin
        ref_mem[word_base(s.addr) + b] = s.data[8*b +: 8];
      end
    end
  endtask

  function automatic wb_pkg::data_t read_ref(input wb_pkg::addr_t a);
    wb_pkg::data_t w;
    for (int b = 0; b < `WB_MASK_W; b++) begin
      w[8*b +: 8] = ref_mem[word_base(a) + b];
    end
    return w;
  endfunction

  // ##############################
  // checks and cycle stepping

  task automatic note_error();
    errors++;
    t_errors++;
  endtask

  task automatic check_value(input wb_pkg::data_t exp, input wb_pkg::data_t act);
    t_checks++;
    if (act !== exp) begin
      $display("error %s: expected %h, actual %h", cur_name, exp, act);
      note_error();
    end
  endtask

  // samples handshakes mid-cycle, then returns 2 ns after the next rising edge.
  task automatic tick();
    logic          st_fire;
    logic          ld_fire;
    wb_pkg::data_t exp;
    @(negedge clk_i);
    st_fire = store_valid_i & store_ready_o;
    ld_fire = load_valid_i & load_ready_o;
    if (result_valid_o) begin
      if (held_v) begin
        check_value(held_data, result_data_o);
      end
      if (result_ready_i) begin
        held_v = 1'b0;
        if (exp_q.size() == 0) begin
          $display("%s: a result came back with no load outstanding", cur_name);
          note_error();
        end else begin
          exp = exp_q.pop_front();
          check_value(exp, result_data_o);
        end
      end else begin
        held_v    = 1'b1;
        held_data = result_data_o;
      end
    end
    // the store lands in the reference first, so a same-cycle load sees it.
    if (st_fire) begin
      write_ref(store_i);
    end
    if (ld_fire) begin
      exp_q.push_back(exp_from_ref ? read_ref(load_addr_i) : cur_exp);
    end
    st_fired = st_fire;
    ld_fired = ld_fire;
    @(posedge clk_i);
    #2;
  endtask

  task automatic transfer(input logic st, input logic ld);
    logic st_p;
    logic ld_p;
    int   n;
    st_p = st;
    ld_p = ld;
    store_valid_i = st;
    load_valid_i  = ld;
    n = 0;
    while ((st_p || ld_p) && n < TIMEOUT) begin
      tick();
      if (st_fired) begin
        st_p = 1'b0;
        store_valid_i = 1'b0;
      end
      if (ld_fired) begin
        ld_p = 1'b0;
        load_valid_i = 1'b0;
      end
      n++;
    end
    if (st_p || ld_p) begin
      $display("%s: timed out waiting for a store or load to be accepted", cur_name);
      note_error();
    end
    store_valid_i = 1'b0;
    load_valid_i  = 1'b0;
  endtask

  task automatic finish_test();
    int n;
    n = 0;
    result_ready_i = 1'b1;
    while (exp_q.size() > 0 && n < TIMEOUT) begin
      tick();
      n++;
    end
    if (exp_q.size() > 0) begin
      $display("%s: timed out with %0d results never returned", cur_name, exp_q.size());
      note_error();
      exp_q.delete();
    end
    $display("test %s: %0d checks, %0d errors", cur_name, t_checks, t_errors);
    tests++;
    checks += t_checks;
    t_checks = 0;
    t_errors = 0;
  endtask

  task automatic add_row(input logic [2:0] test, input logic [1:0] op,
                         input wb_pkg::addr_t addr, input wb_pkg::data_t data,
                         input wb_pkg::mask_t mask, input wb_pkg::data_t exp);
    row_t r;
    r.test = test;
    r.op   = op;
    r.addr = addr;
    r.data = data;
    r.mask = mask;
    r.exp  = exp;
    rows.push_back(r);
  endtask

  // ##############################
  // main sequence

  initial begin
    row_t row;
    int   n;
    int   sent;
    store_valid_i  = 1'b0;
    store_i        = '0;
    load_valid_i   = 1'b0;
    load_addr_i    = '0;
    result_ready_i = 1'b0;
    reset_i        = 1'b1;

    for (int w = 0; w < 8; w++) begin
      add_row(3'd0, OP_ST, 10'(REGION_BASE + 4 * w), 32'h1111_1111 * (w + 1), 4'b1111, 32'h0);
    end
    for (int w = 0; w < 8; w++) begin
      add_row(3'd0, OP_LD, 10'(REGION_BASE + 4 * w), 32'h0, 4'b0000, 32'h1111_1111 * (w + 1));
    end
    add_row(3'd1, OP_ST, 10'h044, 32'haabb_ccdd, 4'b0101, 32'h0);
    add_row(3'd1, OP_LD, 10'h046, 32'h0, 4'b0000, 32'h22bb_22dd);
    add_row(3'd1, OP_ST, 10'h050, 32'h9900_0000, 4'b1000, 32'h0);
    add_row(3'd1, OP_LD, 10'h050, 32'h0, 4'b0000, 32'h9955_5555);
    add_row(3'd2, OP_SL, 10'h048, 32'h5566_7788, 4'b1100, 32'h5566_3333);
    add_row(3'd2, OP_SL, 10'h054, 32'h1234_5678, 4'b0010, 32'h6666_5666);
    add_row(3'd3, OP_ST, 10'h04c, 32'h0102_0304, 4'b0011, 32'h0);
    add_row(3'd3, OP_ST, 10'h04e, 32'ha0b0_c0d0, 4'b0110, 32'h0);
    add_row(3'd3, OP_LD, 10'h04c, 32'h0, 4'b0000, 32'h44b0_c004);

    repeat (2) @(posedge clk_i);
    #2;
    reset_i = 1'b0;
    result_ready_i = 1'b1;

    for (int i = 0; i < rows.size(); i++) begin
      row = rows[i];
      cur_name      = test_names[row.test];
      store_i.addr  = row.addr;
      store_i.data  = row.data;
      store_i.mask  = row.mask;
      load_addr_i   = row.addr;
      cur_exp       = row.exp;
      transfer(row.op != OP_LD, row.op != OP_ST);
      if (i == rows.size() - 1 || rows[i + 1].test != row.test) begin
        finish_test();
      end
    end

    // loads stream in while the result side stalls at random.
    cur_name = test_names[4];
    exp_from_ref = 1'b1;
    sent = 0;
    n = 0;
    load_addr_i    = region_addr();
    load_valid_i   = 1'b1;
    result_ready_i = 1'(rand_bits(1));
    while (sent < 40 && n < TIMEOUT) begin
      tick();
      if (ld_fired) begin
        sent++;
        load_addr_i = region_addr();
      end
      result_ready_i = 1'(rand_bits(1));
      n++;
    end
    load_valid_i = 1'b0;
    if (sent < 40) begin
      $display("%s: timed out after %0d of 40 loads", cur_name, sent);
      note_error();
    end
    finish_test();

    // every cycle takes the array port, so no store drains during the burst.
    cur_name = test_names[5];
    sent = 0;
    store_i       = random_store();
    store_valid_i = 1'b1;
    load_addr_i   = region_addr();
    load_valid_i  = 1'b1;
    for (int c = 0; c < 10; c++) begin
      tick();
      if (st_fired) begin
        sent++;
        store_i = random_store();
      end
      load_addr_i = region_addr();
    end
    check_value(32'd2, wb_pkg::data_t'(sent));
    check_value(32'd0, wb_pkg::data_t'(store_ready_o));
    load_valid_i = 1'b0;
    n = 0;
    while (sent < 4 && n < TIMEOUT) begin
      tick();
      if (st_fired) begin
        sent++;
        store_i = random_store();
      end
      n++;
    end
    store_valid_i = 1'b0;
    n = 0;
    while ((sent < 4 || !store_ready_o) && n < TIMEOUT) begin
      tick();
      n++;
    end
    if (sent < 4 || !store_ready_o) begin
      $display("%s: timed out waiting for the buffered stores to drain", cur_name);
      note_error();
    end
    for (int w = 0; w < 8; w++) begin
      load_addr_i = 10'(REGION_BASE + 4 * w);
      transfer(1'b0, 1'b1);
    end
    finish_test();

    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

/* wb_consts.svh */
/*
  Size constants for the write-buffered cache bank data path.
  Included by the package and by every module that sizes logic from them.
*/

`ifndef WB_CONSTS_SVH
`define WB_CONSTS_SVH

// byte address into the bank.
`define WB_ADDR_W   10
`define WB_DATA_W   32
`define WB_MASK_W   4
`define WB_WORDS    256

// low address bits that pick a byte inside a word.
`define WB_OFFSET_W 2

`endif

/* wb_pkg.sv */
/*
  Shared types for the store path.
  Modules and the testbench refer to these by scoped name.
*/

`include "wb_consts.svh"

package wb_pkg;

  // ##############################
  // plain vectors

  typedef logic [`WB_ADDR_W-1:0]              addr_t;
  typedef logic [`WB_ADDR_W-`WB_OFFSET_W-1:0] word_addr_t;
  typedef logic [`WB_DATA_W-1:0]              data_t;
  typedef logic [`WB_MASK_W-1:0]              mask_t;

  // ##############################
  // bundles

  // one store as it travels from the store port to the array.
  typedef struct packed {
    addr_t addr;
    data_t data;
    mask_t mask;
  } store_entry_t;

  // buffered bytes found for a load; mask bits mark the bytes that override the array.
  typedef struct packed {
    data_t data;
    mask_t mask;
  } bypass_t;

endpackage
